// ==== build.f ====
logic/alu_pkg.sv
logic/alu_decode.sv
logic/operand_forward.sv
logic/alu_addlogic.sv
logic/alu_shifter.sv
logic/result_writeback.sv
logic/alu_lane.sv
bench/alu_sva.sv
bench/alu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module alu_tb -f build.f -o alu_sim
out=$(./obj_dir/alu_sim)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1

// ==== bench/alu_tb.sv ====
module alu_tb;
  import alu_pkg::*;

  logic clk = 1'b0, arst_n, issue_en, flush, result_valid;
  op_word_u op;
  data_t a_val, b_val, ext_result, result;
  fwd_sel_t a_sel, b_sel;
  flags_t flags;

  string    t_name[40];
  logic [12:0] t_op[40];
  data_t    t_a[40], t_b[40], t_ext[40], t_exp[40];
  fwd_sel_t t_as[40], t_bs[40];
  flags_t   t_fx[40];
  int       t_fl[40]; // 0 none, 1 flush at issue, 2 flush one edge later
  int nrows = 0, n_pass = 0, n_err = 0, cyc = 0;
  logic [15:0] lfsr = 16'd39;
  string q_name[$];
  data_t q_res[$];
  flags_t q_flg[$];
  int q_cyc[$];

  alu_lane DUT (.*);
  bind alu_lane alu_sva u_sva (.clk, .arst_n, .issue_en, .result_valid);

  always #2 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  task automatic add_row(input string n, input logic [12:0] o, input data_t a, input data_t b,
                         input fwd_sel_t as, input fwd_sel_t bs, input data_t ext, input int fl,
                         input data_t ex, input flags_t fx);
    t_name[nrows] = n;
    t_op[nrows]   = o;
    t_a[nrows]    = a;
    t_b[nrows]    = b;
    t_as[nrows]   = as;
    t_bs[nrows]   = bs;
    t_ext[nrows]  = ext;
    t_fl[nrows]   = fl;
    t_exp[nrows]  = ex;
    t_fx[nrows]   = fx;
    nrows++;
  endtask

  function automatic logic [12:0] cmp_op(input logic [2:0] mask);
    return {mask, 2'b00, op_cmp};
  endfunction

  function automatic data_t rand_word();
    data_t w;
    for (int k = 0; k < 64; k++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]}; // taps 16,14,13,11
      w[k] = lfsr[0];
    end
    return w;
  endfunction

  task automatic idle_cycle(input logic fl);
    @(posedge clk);
    #1;
    issue_en = 1'b0;
    flush    = fl;
  endtask

  always @(negedge clk) begin
    if (arst_n && result_valid) begin
      if (q_res.size() == 0) begin
        $display("result_valid high with no op pending at cycle %0d", cyc);
        n_err++;
      end else begin
        assert (cyc == q_cyc[0]) else begin
          $display("result for %s arrived at cycle %0d, not %0d", q_name[0], cyc, q_cyc[0]);
          n_err++;
        end
        assert (result == q_res[0] && flags == q_flg[0]) begin
          $display("ok   %s", q_name[0]);
          n_pass++;
        end else begin
          $display("[ERROR] %s expected %h/%h actual %h/%h", q_name[0], q_res[0], q_flg[0],
                   result, flags);
          n_err++;
        end
        void'(q_name.pop_front());
        void'(q_res.pop_front());
        void'(q_flg.pop_front());
        void'(q_cyc.pop_front());
      end
    end
  end

  initial begin
    data_t ra, rb;
    logic [64:0] s;
    arst_n     = 1'b0;
    issue_en   = 1'b0;
    flush      = 1'b0;
    op         = '0;
    a_val      = '0;
    b_val      = '0;
    a_sel      = fwd_port;
    b_sel      = fwd_port;
    ext_result = '0;
    add_row("add64_ovf", 13'(op_add64), 64'h7fffffffffffffff, 1, fwd_port, fwd_port, 0, 0,
            64'h8000000000000000, 4'ha);
    add_row("add64_carry", 13'(op_add64), '1, 1, fwd_port, fwd_port, 0, 0, 0, 4'h5);
    add_row("sub64_eq", 13'(op_sub64), 5, 5, fwd_port, fwd_port, 0, 0, 0, 4'h5);
    add_row("sub64_borrow", 13'(op_sub64), 0, 1, fwd_port, fwd_port, 0, 0, '1, 4'h2);
    add_row("add32_ovf", 13'(op_add32), 64'h7fffffff, 1, fwd_port, fwd_port, 0, 0,
            64'h80000000, 4'ha);
    add_row("sub32_neg", 13'(op_sub32), 3, 5, fwd_port, fwd_port, 0, 0, 64'hfffffffe, 4'h2);
    add_row("and", 13'(op_and), 64'hf0f0, 64'hff00, fwd_port, fwd_port, 0, 0, 64'hf000, 4'h0);
    add_row("or", 13'(op_or), 64'hf0f0, 64'h0f00, fwd_port, fwd_port, 0, 0, 64'hfff0, 4'h0);
    add_row("xor_zero", 13'(op_xor), 64'h1234, 64'h1234, fwd_port, fwd_port, 0, 0, 0, 4'h1);
    add_row("cmp_slt", cmp_op(3'b001), '1, 1, fwd_port, fwd_port, 0, 0, 1, 4'h6);
    add_row("cmp_ult", cmp_op(3'b010), '1, 1, fwd_port, fwd_port, 0, 0, 0, 4'h6);
    add_row("cmp_eq", cmp_op(3'b100), 7, 7, fwd_port, fwd_port, 0, 0, 1, 4'h5);
    add_row("shl64", 13'(op_shl64), 1, 64'h43, fwd_port, fwd_port, 0, 0, 8, 4'h0);
    add_row("shr64", 13'(op_shr64), 64'h8000000000000000, 63, fwd_port, fwd_port, 0, 0, 1, 4'h0);
    add_row("sar64", 13'(op_sar64), 64'h8000000000000000, 4, fwd_port, fwd_port, 0, 0,
            64'hf800000000000000, 4'h2);
    add_row("shl32", 13'(op_shl32), 1, 64'h21, fwd_port, fwd_port, 0, 0, 2, 4'h0);
    add_row("sar32", 13'(op_sar32), 64'h80000000, 31, fwd_port, fwd_port, 0, 0,
            64'hffffffff, 4'h2);
    add_row("shr32", 13'(op_shr32), 64'hffffffff80000000, 31, fwd_port, fwd_port, 0, 0, 1, 4'h0);
    add_row("fwd_ext", 13'(op_add64), 999, 5, fwd_ext, fwd_port, 100, 0, 105, 4'h0);
    add_row("fwd_ext_d", 13'(op_add64), 999, 1, fwd_ext_d, fwd_port, 0, 0, 101, 4'h0);
    add_row("chain_base", 13'(op_add64), 10, 20, fwd_port, fwd_port, 0, 0, 30, 4'h0);
    // own result at issue is the op two slots back
    add_row("chain_own1", 13'(op_add64), 0, 1, fwd_own, fwd_port, 0, 0, 102, 4'h0);
    add_row("chain_own2", 13'(op_add64), 0, 2, fwd_own, fwd_port, 0, 0, 32, 4'h0);
    add_row("chain_own3", 13'(op_sub64), 0, 0, fwd_own, fwd_own, 0, 0, 0, 4'h5);
    add_row("flush_issue", 13'(op_add64), 1, 1, fwd_port, fwd_port, 0, 1, 0, 4'h0);
    add_row("flush_late", 13'(op_add64), 3, 4, fwd_port, fwd_port, 0, 2, 0, 4'h0);
    add_row("after_flush", 13'(op_add64), 5, 5, fwd_port, fwd_port, 0, 0, 10, 4'h0);
    for (int r = 0; r < 8; r++) begin
      ra = rand_word();
      rb = rand_word();
      s  = {1'b0, ra} + {1'b0, rb};
      add_row($sformatf("rand_add%0d", r), 13'(op_add64), ra, rb, fwd_port, fwd_port, 0, 0,
              s[63:0], {ra[63] == rb[63] && s[63] != ra[63], s[64], s[63], s[63:0] == 0});
    end
    fork
      begin
        #((nrows + 20) * 4);
        $display("watchdog expired with results still outstanding");
        $display("ERRORS FOUND");
        $finish;
      end
    join_none
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    assert (!result_valid) else begin
      $display("result_valid high right after reset");
      n_err++;
    end
    for (int i = 0; i < nrows; i++) begin
      if (t_fl[i] != 0) idle_cycle(1'b0); // keep a late flush off the previous op
      @(posedge clk);
      #1;
      issue_en   = 1'b1;
      op         = t_op[i];
      a_val      = t_a[i];
      b_val      = t_b[i];
      a_sel      = t_as[i];
      b_sel      = t_bs[i];
      ext_result = t_ext[i];
      flush      = (t_fl[i] == 1);
      if (t_fl[i] == 0) begin
        q_name.push_back(t_name[i]);
        q_res.push_back(t_exp[i]);
        q_flg.push_back(t_fx[i]);
        q_cyc.push_back(cyc + 2);
      end else begin
        idle_cycle(t_fl[i] == 2); // late flush lands on the edge after issue
        idle_cycle(1'b0);
        assert (!result_valid) begin
          $display("ok   %s killed", t_name[i]);
          n_pass++;
        end else begin
          $display("%s was flushed but result_valid still rose", t_name[i]);
          n_err++;
        end
      end
    end
    idle_cycle(1'b0);
    while (q_res.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    $display("tests %0d passed %0d errors %0d", nrows, n_pass, n_err);
    if (n_err == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== bench/alu_sva.sv ====
module alu_sva (
  input logic clk,
  input logic arst_n,
  input logic issue_en,
  input logic result_valid
);

  // no result may show while the lane is held in reset
  property p_quiet_in_reset;
    @(posedge clk) !arst_n |-> !result_valid;
  endproperty

  // every result traces back to an issue two edges earlier
  property p_valid_after_issue;
    @(posedge clk) disable iff (!arst_n)
      result_valid |-> $past(issue_en, 2);
  endproperty

  a_quiet_in_reset: assert property (p_quiet_in_reset)
    else $error("result_valid high during reset");

  a_valid_after_issue: assert property (p_valid_after_issue)
    else $error("result_valid without an issue two edges back");

endmodule

// ==== logic/alu_lane.sv ====
module alu_lane (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              issue_en,
  input  alu_pkg::op_word_u op,
  input  alu_pkg::data_t    a_val,
  input  alu_pkg::data_t    b_val,
  input  alu_pkg::fwd_sel_t a_sel,
  input  alu_pkg::fwd_sel_t b_sel,
  input  alu_pkg::data_t    ext_result,
  input  logic              flush,
  output alu_pkg::data_t    result,
  output alu_pkg::flags_t   flags,
  output logic              result_valid
);
  import alu_pkg::*;

  logic       dec_valid, sub_en, is_cmp, half, shl, arith;
  logic [2:0] cmp_mask;
  logic [1:0] logic_sel;
  unit_t      unit;
  data_t      a_op, b_op;
  data_t      sum, shifted;
  flags_t     sum_flags, shift_flags;

  alu_decode u_decode (
    .clk, .arst_n, .issue_en, .flush, .op,
    .dec_valid, .unit, .sub_en, .is_cmp, .cmp_mask, .logic_sel,
    .half, .shl, .arith
  );

  operand_forward u_fwd_a (
    .clk, .arst_n, .issue_en, .port_val(a_val), .sel(a_sel),
    .own_result(result), .ext_result, .operand(a_op)
  );

  operand_forward u_fwd_b (
    .clk, .arst_n, .issue_en, .port_val(b_val), .sel(b_sel),
    .own_result(result), .ext_result, .operand(b_op)
  );

  alu_addlogic u_addlogic (
    .a(a_op), .b(b_op), .sub_en, .is_cmp, .cmp_mask, .logic_sel, .half,
    .sum, .sum_flags
  );

  alu_shifter u_shifter (
    .a(a_op), .b(b_op), .half, .shl, .arith, .shifted, .shift_flags
  );

  result_writeback u_wb (
    .clk, .arst_n, .dec_valid, .flush, .unit, .sum, .sum_flags,
    .shifted, .shift_flags, .result, .flags, .result_valid
  );

endmodule

// ==== logic/result_writeback.sv ====
module result_writeback (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            dec_valid,
  input  logic            flush,
  input  alu_pkg::unit_t  unit,
  input  alu_pkg::data_t  sum,
  input  alu_pkg::flags_t sum_flags,
  input  alu_pkg::data_t  shifted,
  input  alu_pkg::flags_t shift_flags,
  output alu_pkg::data_t  result,
  output alu_pkg::flags_t flags,
  output logic            result_valid
);
  import alu_pkg::*;

  data_t  res_mux;
  flags_t flg_mux;

  assign res_mux = (unit == unit_shift) ? shifted : sum;
  assign flg_mux = (unit == unit_shift) ? shift_flags : sum_flags;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result       <= '0;
      flags        <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= dec_valid && !flush;
      if (dec_valid) begin // own-result bypass reads the held value
        result <= res_mux;
        flags  <= flg_mux;
      end
    end
  end

endmodule

// ==== logic/alu_shifter.sv ====
module alu_shifter (
  input  alu_pkg::data_t  a,
  input  alu_pkg::data_t  b,
  input  logic            half,
  input  logic            shl,
  input  logic            arith,
  output alu_pkg::data_t  shifted,
  output alu_pkg::flags_t shift_flags
);
  import alu_pkg::*;

  logic [5:0] cnt;
  data_t      src;
  data_t      res;

  assign cnt = half ? {1'b0, b[4:0]} : b[5:0];

  // widen the low word first so shr/sar see the right upper bits
  always_comb begin
    if (!half)      src = a;
    else if (arith) src = {{32{a[31]}}, a[31:0]};
    else            src = {32'b0, a[31:0]};
  end

  always_comb begin
    if (shl)        res = src << cnt;
    else if (arith) res = $signed(src) >>> cnt;
    else            res = src >> cnt;
  end

  assign shifted = half ? {32'b0, res[31:0]} : res;

  always_comb begin
    shift_flags = '0; // c and v stay clear
    if (half) begin
      shift_flags[flag_z] = (res[31:0] == 32'b0);
      shift_flags[flag_s] = res[31];
    end else begin
      shift_flags[flag_z] = (res == '0);
      shift_flags[flag_s] = res[xlen-1];
    end
  end

endmodule

// ==== logic/alu_addlogic.sv ====
module alu_addlogic (
  input  alu_pkg::data_t  a,
  input  alu_pkg::data_t  b,
  input  logic            sub_en,
  input  logic            is_cmp,
  input  logic [2:0]      cmp_mask,
  input  logic [1:0]      logic_sel,
  input  logic            half,
  output alu_pkg::data_t  sum,
  output alu_pkg::flags_t sum_flags
);
  import alu_pkg::*;

  data_t         b_eff;
  logic [xlen:0] full;
  logic [32:0]   low;   // carry out of bit 31
  logic          az, as, ac, av;
  logic [2:0]    rel;
  logic          hit;
  data_t         raw;

  assign b_eff = sub_en ? ~b : b;
  assign full  = {1'b0, a} + {1'b0, b_eff} + {{xlen{1'b0}}, sub_en};
  assign low   = {1'b0, a[31:0]} + {1'b0, b_eff[31:0]} + {32'b0, sub_en};

  always_comb begin
    if (half) begin
      az = (full[31:0] == 32'b0);
      as = full[31];
      ac = low[32];
      av = (a[31] == b_eff[31]) && (full[31] != a[31]);
    end else begin
      az = (full[xlen-1:0] == '0);
      as = full[xlen-1];
      ac = full[xlen];
      av = (a[xlen-1] == b_eff[xlen-1]) && (full[xlen-1] != a[xlen-1]);
    end
    rel        = 3'b000;
    rel[cmp_s] = as ^ av;
    rel[cmp_u] = !ac;     // no carry means borrow
    rel[cmp_e] = az;
    hit = (|(cmp_mask & rel)) ^ logic_sel[0];
  end

  always_comb begin
    if (is_cmp) begin
      raw = {{(xlen-1){1'b0}}, hit};
    end else begin
      case (logic_sel)
        lsel_and: raw = a & b;
        lsel_or:  raw = a | b;
        lsel_xor: raw = a ^ b;
        default:  raw = full[xlen-1:0];
      endcase
    end
    sum = half ? {32'b0, raw[31:0]} : raw;
    if (is_cmp || logic_sel == lsel_arith) begin
      sum_flags = {av, ac, as, az};
    end else begin
      sum_flags         = '0;
      sum_flags[flag_z] = (sum == '0);
      sum_flags[flag_s] = half ? raw[31] : raw[xlen-1];
    end
  end

endmodule

// ==== logic/operand_forward.sv ====
module operand_forward (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              issue_en,
  input  alu_pkg::data_t    port_val,
  input  alu_pkg::fwd_sel_t sel,
  input  alu_pkg::data_t    own_result,
  input  alu_pkg::data_t    ext_result,
  output alu_pkg::data_t    operand
);
  import alu_pkg::*;

  data_t ext_d; // ext bus one edge back
  data_t pick;

  always_comb begin
    case (sel)
      fwd_own:   pick = own_result;
      fwd_ext:   pick = ext_result;
      fwd_ext_d: pick = ext_d;
      default:   pick = port_val;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ext_d   <= '0;
      operand <= '0;
    end else begin
      ext_d <= ext_result;
      if (issue_en) operand <= pick;
    end
  end

endmodule

// ==== logic/alu_decode.sv ====
module alu_decode (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             issue_en,
  input  logic             flush,
  input  alu_pkg::op_word_u op,
  output logic             dec_valid,
  output alu_pkg::unit_t   unit,
  output logic             sub_en,
  output logic             is_cmp,
  output logic [2:0]       cmp_mask,
  output logic [1:0]       logic_sel,
  output logic             half,
  output logic             shl,
  output logic             arith
);
  import alu_pkg::*;

  unit_t      d_unit;
  logic       d_sub, d_cmp, d_half, d_shl, d_arith;
  logic [2:0] d_mask;
  logic [1:0] d_lsel;
  logic       valid_q;

  always_comb begin
    d_unit  = unit_add;
    d_sub   = 1'b0;
    d_cmp   = 1'b0;
    d_mask  = 3'b000;
    d_lsel  = lsel_arith;
    d_half  = op.arith.half;
    d_shl   = 1'b0;
    d_arith = 1'b0;
    if (op.cmp.opc[7:1] == cmp_group) begin
      d_cmp  = 1'b1;
      d_sub  = 1'b1;
      d_mask = op.cmp.mask;
      d_half = op.cmp.cond[0];
      d_lsel = {1'b0, op.cmp.cond[1]}; // carries the negate bit on compares
    end else begin
      case (op.arith.opc)
        op_sub64: d_sub = 1'b1;
        op_add32: d_half = 1'b1;
        op_sub32: begin
          d_sub  = 1'b1;
          d_half = 1'b1;
        end
        op_and: d_lsel = lsel_and;
        op_or:  d_lsel = lsel_or;
        op_xor: d_lsel = lsel_xor;
        op_shl64, op_shl32: begin
          d_unit = unit_shift;
          d_shl  = 1'b1;
          d_half = d_half | (op.arith.opc == op_shl32);
        end
        op_shr64, op_shr32: begin
          d_unit = unit_shift;
          d_half = d_half | (op.arith.opc == op_shr32);
        end
        op_sar64, op_sar32: begin
          d_unit  = unit_shift;
          d_arith = 1'b1;
          d_half  = d_half | (op.arith.opc == op_sar32);
        end
        default: ; // unknown ops fall to add
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) valid_q <= 1'b0;
    else         valid_q <= issue_en && !flush;
  end

  always_ff @(posedge clk) begin
    if (issue_en) begin
      unit      <= d_unit;
      sub_en    <= d_sub;
      is_cmp    <= d_cmp;
      cmp_mask  <= d_mask;
      logic_sel <= d_lsel;
      half      <= d_half;
      shl       <= d_shl;
      arith     <= d_arith;
    end
  end

  assign dec_valid = valid_q && !flush; // late flush kills too

endmodule

// ==== logic/alu_pkg.sv ====
package alu_pkg;

  localparam int xlen = 64;

  typedef logic [xlen-1:0] data_t;
  typedef logic [3:0]      flags_t;

  // flag bit positions
  localparam int flag_z = 0;
  localparam int flag_s = 1;
  localparam int flag_c = 2;
  localparam int flag_v = 3;

  localparam logic [7:0] op_add64 = 8'h01;
  localparam logic [7:0] op_sub64 = 8'h02;
  localparam logic [7:0] op_add32 = 8'h03;
  localparam logic [7:0] op_sub32 = 8'h04;
  localparam logic [7:0] op_and   = 8'h05;
  localparam logic [7:0] op_or    = 8'h06;
  localparam logic [7:0] op_xor   = 8'h07;
  localparam logic [7:0] op_shl64 = 8'h08;
  localparam logic [7:0] op_shr64 = 8'h09;
  localparam logic [7:0] op_sar64 = 8'h0a;
  localparam logic [7:0] op_shl32 = 8'h0b;
  localparam logic [7:0] op_shr32 = 8'h0c;
  localparam logic [7:0] op_sar32 = 8'h0d;

  // compare family ignores the low opcode bit
  localparam logic [6:0] cmp_group = 7'd30;
  localparam logic [7:0] op_cmp    = {cmp_group, 1'b0};

  // compare mask bits
  localparam int cmp_s = 0; // signed less
  localparam int cmp_u = 1; // unsigned less
  localparam int cmp_e = 2; // equal

  localparam logic [1:0] lsel_arith = 2'd0;
  localparam logic [1:0] lsel_and   = 2'd1;
  localparam logic [1:0] lsel_or    = 2'd2;
  localparam logic [1:0] lsel_xor   = 2'd3;

  typedef struct packed {
    logic [3:0] spare;
    logic       half;  // force 32-bit form
    logic [7:0] opc;
  } arith_view_t;

  // cond[0] sits on the half bit and cond[1] negates the hit
  typedef struct packed {
    logic [2:0] mask;
    logic [1:0] cond;
    logic [7:0] opc;
  } cmp_view_t;

  typedef union packed {
    arith_view_t arith;
    cmp_view_t   cmp;
  } op_word_u;

  typedef enum logic [1:0] {fwd_port, fwd_own, fwd_ext, fwd_ext_d} fwd_sel_t;
  typedef enum logic {unit_add, unit_shift} unit_t;

endpackage
